/* source/fetch_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types for the fetch unit and its predictor
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

    // One machine word, used for both addresses and instructions
    typedef logic [31:0] word_t;

    // Two-bit saturating predictor state
    // Upper half predicts taken, lower half predicts sequential
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } pred_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Branch resolution from later in the pipeline
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // Resolved instruction was a branch
        logic  branch;
        // Actual direction
        logic  taken;
        // Fetched path was wrong, redirect needed
        logic  mispredict;
        // Address of the resolved branch
        word_t branch_pc;
        // Correct next address
        word_t dest;
    } resolve_t;

    ////////////////////////////////////////////////////////////////////////////
    // Registered fetch output
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // Address of the fetched word
        word_t pc;
        // Predicted address of the following fetch
        word_t npc;
        // Fetched instruction
        word_t instr;
    } fetch_t;

endpackage

/* source/instruction_rom.sv */
`timescale 1ns/1ns

////////////////////////////////////////////////////////////////////////////
// Instruction store, read only, asynchronous read
////////////////////////////////////////////////////////////////////////////

module instruction_rom import fetch_pkg::*; #(
    parameter int DEPTH = 32
) (
    input  word_t fetch_addr,
    output word_t instr_word
);

    // Entry select width
    localparam int IDX_W = $clog2(DEPTH);

    // Program image
    word_t rom [DEPTH];

    // Entry selected by the word index
    logic [IDX_W-1:0] rd_idx;

    // Contents fixed at time zero
    initial begin
        $readmemh("program.hex", rom);
    end

    // Only the low index bits address the store
    assign rd_idx = fetch_addr[IDX_W-1:0];

    // Combinational read, same cycle as the address
    assign instr_word = rom[rd_idx];

endmodule

/* source/target_buffer.sv */
`timescale 1ns/1ns

////////////////////////////////////////////////////////////////////////////
// Next-address table
////////////////////////////////////////////////////////////////////////////

module target_buffer import fetch_pkg::*; #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     target_we,
    input  logic [$clog2(DEPTH)-1:0] target_idx,
    input  word_t                    target_data,
    input  word_t                    fetch_addr,
    output word_t                    pred_next
);

    localparam int IDX_W = $clog2(DEPTH);

    // Predicted successor per entry
    word_t next_addr [DEPTH];

    // Read select from the fetch address
    logic [IDX_W-1:0] rd_idx;

    assign rd_idx = fetch_addr[IDX_W-1:0];

    // Old contents are seen here on a write edge
    assign pred_next = next_addr[rd_idx];

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Every entry points at the sequential successor
            for (int i = 0; i < DEPTH; i++) begin
                next_addr[i] <= word_t'(i + 1);
            end
        end else if (target_we) begin
            // Learned destination replaces the stored one
            next_addr[target_idx] <= target_data;
        end
    end

endmodule

/* source/predictor_table.sv */
`timescale 1ns/1ns

////////////////////////////////////////////////////////////////////////////
// Per-entry 2-bit saturating counters
////////////////////////////////////////////////////////////////////////////

module predictor_table import fetch_pkg::*; #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_stall,
    input  resolve_t                 resolve,
    output logic                     target_we,
    output logic [$clog2(DEPTH)-1:0] target_idx,
    output word_t                    target_data
);

    localparam int IDX_W = $clog2(DEPTH);

    // Counter bank
    pred_state_e counter [DEPTH];

    // Entry of the resolved branch
    logic [IDX_W-1:0] upd_idx;
    // Current and stepped state of that entry
    pred_state_e      cur_state;
    pred_state_e      nxt_state;
    // Training allowed this cycle
    logic             step_en;
    // Step moves across the taken boundary
    logic             crosses;

    // One saturating step toward the resolved direction
    function automatic pred_state_e step_state(input pred_state_e s, input logic tkn);
        pred_state_e r;
        r = s;
        if (tkn) begin
            case (s)
                strong_nt: r = weak_nt;
                weak_nt:   r = weak_t;
                weak_t:    r = strong_t;
                default:   r = strong_t;
            endcase
        end else begin
            case (s)
                strong_t:  r = weak_t;
                weak_t:    r = weak_nt;
                weak_nt:   r = strong_nt;
                default:   r = strong_nt;
            endcase
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Step and boundary decision
    ////////////////////////////////////////////////////////////////////////////

    assign upd_idx   = resolve.branch_pc[IDX_W-1:0];
    assign cur_state = counter[upd_idx];
    assign nxt_state = step_state(cur_state, resolve.taken);

    // Memory stall freezes training too
    assign step_en = resolve.branch && !mem_stall;

    // weak_nt -> weak_t on taken, weak_t -> weak_nt on not taken
    assign crosses = (resolve.taken && (cur_state == weak_nt)) ||
                     (!resolve.taken && (cur_state == weak_t));

    // Target rewrite request
    assign target_we   = step_en && crosses;
    assign target_idx  = upd_idx;
    assign target_data = resolve.dest;

    ////////////////////////////////////////////////////////////////////////////
    // Counter update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Start weakly sequential
            for (int i = 0; i < DEPTH; i++) begin
                counter[i] <= weak_nt;
            end
        end else if (step_en) begin
            counter[upd_idx] <= nxt_state;
        end
    end

endmodule

/* source/fetch_sequencer.sv */
`timescale 1ns/1ns

////////////////////////////////////////////////////////////////////////////
// Program counter and fetch output registers
////////////////////////////////////////////////////////////////////////////

module fetch_sequencer import fetch_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     mem_stall,
    input  resolve_t resolve,
    input  word_t    instr_word,
    input  word_t    pred_next,
    output word_t    fetch_addr,
    output fetch_t   fetch
);

    // Register load and its contents
    logic   load_en;
    fetch_t fetch_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // Address select
    ////////////////////////////////////////////////////////////////////////////

    // Redirect target wins over the held prediction
    always_comb begin
        if (resolve.mispredict) begin
            fetch_addr = resolve.dest;
        end else begin
            fetch_addr = fetch.npc;
        end
    end

    // Same fill for redirect and advance
    // ROM word and prediction both follow fetch_addr
    always_comb begin
        fetch_nxt.pc    = fetch_addr;
        fetch_nxt.npc   = pred_next;
        fetch_nxt.instr = instr_word;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Priority: mem_stall, mispredict, stall, advance
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (mem_stall) begin
            // Whole unit frozen
            load_en = 1'b0;
        end else if (resolve.mispredict) begin
            // Flush overrides pipeline stall
            load_en = 1'b1;
        end else if (stall) begin
            load_en = 1'b0;
        end else begin
            // Sequential or predicted step
            load_en = 1'b1;
        end
    end

    // Output registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch.pc    <= '0;
            fetch.npc   <= '0;
            fetch.instr <= '0;
        end else if (load_en) begin
            fetch <= fetch_nxt;
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ns

////////////////////////////////////////////////////////////////////////////
// Fetch unit top level
////////////////////////////////////////////////////////////////////////////

module fetch_unit import fetch_pkg::*; #(
    parameter int DEPTH = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     mem_stall,
    input  resolve_t resolve,
    output fetch_t   fetch
);

    localparam int IDX_W = $clog2(DEPTH);

    // Fetch address and what it reads
    word_t fetch_addr;
    word_t instr_word;
    word_t pred_next;

    // Predictor to target table write port
    logic             target_we;
    logic [IDX_W-1:0] target_idx;
    word_t            target_data;

    ////////////////////////////////////////////////////////////////////////////
    // PC and output registers
    ////////////////////////////////////////////////////////////////////////////

    fetch_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .mem_stall  (mem_stall),
        .resolve    (resolve),
        .instr_word (instr_word),
        .pred_next  (pred_next),
        .fetch_addr (fetch_addr),
        .fetch      (fetch)
    );

    // Program store
    instruction_rom #(
        .DEPTH (DEPTH)
    ) u_rom (
        .fetch_addr (fetch_addr),
        .instr_word (instr_word)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Branch prediction
    ////////////////////////////////////////////////////////////////////////////

    // Next-address table
    target_buffer #(
        .DEPTH (DEPTH)
    ) u_tgt (
        .clk         (clk),
        .rst         (rst),
        .target_we   (target_we),
        .target_idx  (target_idx),
        .target_data (target_data),
        .fetch_addr  (fetch_addr),
        .pred_next   (pred_next)
    );

    // Counters and rewrite decision
    predictor_table #(
        .DEPTH (DEPTH)
    ) u_pred (
        .clk         (clk),
        .rst         (rst),
        .mem_stall   (mem_stall),
        .resolve     (resolve),
        .target_we   (target_we),
        .target_idx  (target_idx),
        .target_data (target_data)
    );

endmodule

/* testbench/fetch_ref_model.svh */
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

// Model copies of ROM, next-address table and counters
word_t       m_rom     [DEPTH];
word_t       m_table   [DEPTH];
pred_state_e m_counter [DEPTH];
fetch_t      m_fetch;

// Table entry addressed by a word index
function automatic int unsigned model_idx(input word_t a);
    return a % DEPTH;
endfunction

task automatic model_load();
    $readmemh("program.hex", m_rom);
endtask

// Reset image: sequential targets, weakly not taken
task automatic model_reset();
    for (int i = 0; i < DEPTH; i++) begin
        m_table[i]   = word_t'(i + 1);
        m_counter[i] = weak_nt;
    end
    m_fetch = '0;
endtask

// Next fetch register value from the current one and this cycle's inputs
function automatic fetch_t ref_next_fetch(input fetch_t cur, input logic st,
                                          input logic ms, input resolve_t r);
    fetch_t nxt;
    word_t  addr;
    nxt = cur;
    if (ms) begin
        return nxt;
    end
    if (r.mispredict) begin
        addr = r.dest;
    end else if (st) begin
        return nxt;
    end else begin
        addr = cur.npc;
    end
    nxt.pc    = addr;
    nxt.npc   = m_table[model_idx(addr)];
    nxt.instr = m_rom[model_idx(addr)];
    return nxt;
endfunction

// Counter step and target rewrite on a resolved branch
function automatic void model_train(input resolve_t r, input logic ms);
    pred_state_e s;
    int unsigned i;
    if (ms || !r.branch) begin
        return;
    end
    i = model_idx(r.branch_pc);
    s = m_counter[i];
    // Crossing the middle rewrites the target
    if ((r.taken && s == weak_nt) || (!r.taken && s == weak_t)) begin
        m_table[i] = r.dest;
    end
    if (r.taken && s != strong_t) begin
        m_counter[i] = pred_state_e'(s + 2'd1);
    end else if (!r.taken && s != strong_nt) begin
        m_counter[i] = pred_state_e'(s - 2'd1);
    end
endfunction

`endif

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/1ns

module tb_fetch_unit import fetch_pkg::*; ();

    localparam int DEPTH      = 32;
    localparam int N_DIRECTED = 64;
    localparam int N_RANDOM   = 400;
    // Reset, directed and random cycles plus slack
    localparam int TIMEOUT_NS = (8 + N_DIRECTED + N_RANDOM + 20) * 10;

    logic     clk;
    logic     rst;
    logic     stall;
    logic     mem_stall;
    resolve_t resolve;
    fetch_t   fetch;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'd72914;

    `include "fetch_ref_model.svh"

    fetch_unit #(
        .DEPTH (DEPTH)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .mem_stall (mem_stall),
        .resolve   (resolve),
        .fetch     (fetch)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic resolve_t make_resolve(input logic b, input logic t, input logic m,
                                              input word_t pc, input word_t d);
        resolve_t r;
        r.branch     = b;
        r.taken      = t;
        r.mispredict = m;
        r.branch_pc  = pc;
        r.dest       = d;
        return r;
    endfunction

    // Input values for the next edge, driven right after this one
    task automatic apply(input logic s, input logic ms, input resolve_t r);
        @(posedge clk);
        stall     <= s;
        mem_stall <= ms;
        resolve   <= r;
    endtask

    task automatic compare_word(input word_t act, input word_t exp, input string field);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s mismatch, got %h expected %h", $time, field, act, exp);
        end
    endtask

    task automatic compare_fetch(input fetch_t act, input fetch_t exp, input string tag);
        compare_word(act.pc, exp.pc, {tag, " pc"});
        compare_word(act.npc, exp.npc, {tag, " npc"});
        compare_word(act.instr, exp.instr, {tag, " instr"});
    endtask

    // Free-run for at most 16 edges until the given pc shows up
    task automatic run_until_pc(input word_t target);
        int n;
        n = 0;
        @(negedge clk);
        while (fetch.pc !== target && n < 16) begin
            apply(1'b0, 1'b0, '0);
            @(negedge clk);
            n++;
        end
        if (fetch.pc !== target) begin
            errors++;
            $display("Sequential fetch never reached pc %0d", target);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model compare on every cycle
    ////////////////////////////////////////////////////////////////////////////

    // Model steps on the edge and is checked at the following negedge
    initial begin
        fetch_t exp;
        model_load();
        model_reset();
        forever begin
            @(posedge clk);
            if (rst) begin
                model_reset();
            end else begin
                // Table read before this edge's write
                exp = ref_next_fetch(m_fetch, stall, mem_stall, resolve);
                model_train(resolve, mem_stall);
                m_fetch = exp;
            end
            @(negedge clk);
            compare_fetch(fetch, m_fetch, "model");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        fetch_t   held;
        fetch_t   exp;
        resolve_t r;
        logic     s;
        logic     ms;
        rst       = 1'b1;
        stall     = 1'b0;
        mem_stall = 1'b0;
        resolve   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Sequential fetch from zero
        for (int i = 0; i < 6; i++) begin
            apply(1'b0, 1'b0, '0);
            @(negedge clk);
            exp.pc    = word_t'(i);
            exp.npc   = word_t'(i + 1);
            exp.instr = m_rom[i];
            compare_fetch(fetch, exp, "sequential");
        end

        // Stall high for three edges, then fetch moves on to the held npc
        apply(1'b1, 1'b0, '0);
        @(negedge clk);
        held = fetch;
        repeat (2) apply(1'b1, 1'b0, '0);
        apply(1'b0, 1'b0, '0);
        @(negedge clk);
        compare_fetch(fetch, held, "stall hold");
        apply(1'b0, 1'b0, '0);
        @(negedge clk);
        compare_word(fetch.pc, held.npc, "stall release pc");

        // Memory stall with a taken branch at 20 freezes fetch and training
        apply(1'b0, 1'b1, make_resolve(1'b1, 1'b1, 1'b0, 32'd20, 32'd7));
        @(negedge clk);
        held = fetch;
        apply(1'b0, 1'b1, make_resolve(1'b1, 1'b1, 1'b0, 32'd20, 32'd7));
        apply(1'b0, 1'b0, '0);
        @(negedge clk);
        compare_fetch(fetch, held, "mem_stall hold");
        apply(1'b0, 1'b0, '0);

        // Redirect to 20 under stall, entry 20 still sequential
        apply(1'b1, 1'b0, make_resolve(1'b0, 1'b0, 1'b1, 32'd0, 32'd20));
        apply(1'b0, 1'b0, '0);
        @(negedge clk);
        exp.pc    = 32'd20;
        exp.npc   = 32'd21;
        exp.instr = m_rom[20];
        compare_fetch(fetch, exp, "redirect");

        // Train branch at 12 toward 3, second resolution redirects
        apply(1'b0, 1'b0, make_resolve(1'b1, 1'b1, 1'b0, 32'd12, 32'd3));
        apply(1'b0, 1'b0, make_resolve(1'b1, 1'b1, 1'b1, 32'd12, 32'd3));
        apply(1'b0, 1'b0, '0);
        run_until_pc(32'd12);
        compare_word(fetch.npc, 32'd3, "learned npc");

        // strong_t to weak_t keeps the target
        apply(1'b0, 1'b0, make_resolve(1'b1, 1'b0, 1'b0, 32'd12, 32'd13));
        apply(1'b0, 1'b0, '0);
        run_until_pc(32'd12);
        compare_word(fetch.npc, 32'd3, "kept npc");

        // Random mix
        for (int n = 0; n < N_RANDOM; n++) begin
            s            = (next_rand() % 4) == 0;
            ms           = (next_rand() % 8) == 0;
            r.branch     = next_rand() % 2;
            r.taken      = next_rand() % 2;
            r.mispredict = (next_rand() % 5) == 0;
            r.branch_pc  = next_rand() % DEPTH;
            r.dest       = next_rand() % DEPTH;
            apply(s, ms, r);
        end

        apply(1'b0, 1'b0, '0);
        apply(1'b0, 1'b0, '0);
        @(negedge clk);
        #1;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+testbench
source/fetch_pkg.sv
source/instruction_rom.sv
source/target_buffer.sv
source/predictor_table.sv
source/fetch_sequencer.sv
source/fetch_unit.sv
testbench/tb_fetch_unit.sv

/* program.hex */
// One 32-bit instruction word per line, hex, word index 0 upward
00000013
00100093
00200113
002081b3
40110233
0041f2b3
0052e333
005343b3
00739413
0033d493
00a00513
00b50593
fea58ee3
00c58633
0062a6b3
00d68733
00e707b3
00f78833
010808b3
01188933
c0ffee01
012909b3
01398a33
014a0ab3
015a8b33
016b0bb3
017b8c33
018c0cb3
019c8d33
01ad0db3
01bd8e33
00008067
